// ==== compile.f ====
design/kbd_pkg.sv
design/av_pkg.sv
design/scan_bus_if.sv
design/ps2_receiver.sv
design/key_decoder.sv
design/audio_dac.sv
design/arcade_shell.sv
verification/arcade_shell_tb.sv

// ==== design/arcade_shell.sv ====
`timescale 1ns/1ns

module arcade_shell import kbd_pkg::*, av_pkg::*; #(
	parameter int IDLE_TIMEOUT = 2000,
	parameter int SAMPLE_WIDTH = DEFAULT_SAMPLE_WIDTH
) (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  logic                    ps2_clk,
	input  logic                    ps2_data,
	input  logic [SAMPLE_WIDTH-1:0] audio1,
	input  logic [SAMPLE_WIDTH-1:0] audio2,
	output logic [NUM_KEYS-1:0]     keys,
	output logic                    frame_err,
	output logic                    audio_out
);

	// Decoded bytes from receiver to key table
	scan_bus_if scan_bus_i ();

	ps2_receiver #(
		.IDLE_TIMEOUT(IDLE_TIMEOUT)
	) ps2_receiver_i (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.ps2_clk   (ps2_clk),
		.ps2_data  (ps2_data),
		.frame_err (frame_err),
		.scan      (scan_bus_i.receiver)
	);

	// Control vector toward the game core
	key_decoder key_decoder_i (
		.clk_sys (clk_sys),
		.rst     (rst),
		.scan    (scan_bus_i.decoder),
		.keys    (keys)
	);

	// Both sound channels into one bit stream
	audio_dac #(
		.SAMPLE_WIDTH(SAMPLE_WIDTH)
	) audio_dac_i (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.audio1    (audio1),
		.audio2    (audio2),
		.audio_out (audio_out)
	);

endmodule

// ==== design/audio_dac.sv ====
`timescale 1ns/1ns

module audio_dac import av_pkg::*; #(
	parameter int SAMPLE_WIDTH = DEFAULT_SAMPLE_WIDTH
) (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  logic [SAMPLE_WIDTH-1:0] audio1,
	input  logic [SAMPLE_WIDTH-1:0] audio2,
	output logic                    audio_out
);

	localparam int MIX_WIDTH = SAMPLE_WIDTH + MIX_HEADROOM;
	// Both channels at full scale
	localparam int MAX_MIX   = 2 * ((1 << SAMPLE_WIDTH) - 1);

	logic [MIX_WIDTH-1:0] mix;
	logic [MIX_WIDTH-1:0] acc;

	// Unsigned sum of both channels
	always_ff @(posedge clk_sys) begin
		mix <= MIX_WIDTH'(audio1) + MIX_WIDTH'(audio2);
	end

	// First order sigma-delta
	// the carry out of the wrap is the output bit, so over
	// 2**MIX_WIDTH cycles it is high exactly mix times
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			acc       <= '0;
			audio_out <= 1'b0;
		end else begin
			{audio_out, acc} <= {1'b0, acc} + {1'b0, mix};
		end
	end

	assert property (@(posedge clk_sys) disable iff (rst) mix <= MIX_WIDTH'(MAX_MIX));

endmodule

// ==== design/av_pkg.sv ====
package av_pkg;

	// Sound channel width of the game core
	localparam int DEFAULT_SAMPLE_WIDTH = 7;

	// Extra bits on top of one sample so the sum of two channels
	// never wraps; also sets the accumulator width of the modulator
	localparam int MIX_HEADROOM = 1;

endpackage

// ==== design/kbd_pkg.sv ====
package kbd_pkg;

	// One byte as it comes off the PS/2 wire
	typedef logic [7:0] scan_code_t;

	// Prefix bytes folded into flags by the receiver
	localparam scan_code_t PREFIX_EXTENDED = 8'hE0;
	localparam scan_code_t PREFIX_BREAK    = 8'hF0;

	// Width of the arcade control vector
	localparam int NUM_KEYS = 10;

	// Bit positions in the control vector
	localparam int KEY_RIGHT  = 0;
	localparam int KEY_LEFT   = 1;
	localparam int KEY_UP     = 2;
	localparam int KEY_DOWN   = 3;
	localparam int KEY_GAS    = 4;
	localparam int KEY_START1 = 5;
	localparam int KEY_START2 = 6;
	localparam int KEY_COIN   = 7;
	localparam int KEY_TEST   = 8;
	localparam int KEY_TRACK  = 9;

	// Set 2 scancode for each control bit
	function automatic scan_code_t key_code(input int idx);
		case (idx)
			KEY_RIGHT:  key_code = 8'h74;
			KEY_LEFT:   key_code = 8'h6B;
			KEY_UP:     key_code = 8'h75;
			KEY_DOWN:   key_code = 8'h72;
			KEY_GAS:    key_code = 8'h29;
			KEY_START1: key_code = 8'h16;
			KEY_START2: key_code = 8'h1E;
			KEY_COIN:   key_code = 8'h2E;
			KEY_TEST:   key_code = 8'h2C;
			KEY_TRACK:  key_code = 8'h31;
			default:    key_code = 8'h00;
		endcase
	endfunction

	// Arrow keys arrive behind an E0 prefix
	function automatic logic key_ext(input int idx);
		return idx inside {KEY_RIGHT, KEY_LEFT, KEY_UP, KEY_DOWN};
	endfunction

endpackage

// ==== design/key_decoder.sv ====
`timescale 1ns/1ns

module key_decoder import kbd_pkg::*; (
	input  logic                clk_sys,
	input  logic                rst,
	scan_bus_if.decoder         scan,
	output logic [NUM_KEYS-1:0] keys
);

	// One bit per table entry that matches the byte on the bus
	logic [NUM_KEYS-1:0] hit;

	// Code and extended flag must both agree, so a plain 74
	// does not steer right
	always_comb begin
		for (int i = 0; i < NUM_KEYS; i++) begin
			hit[i] = (scan.code == key_code(i)) && (scan.extended == key_ext(i));
		end
	end

	// Make sets the bit, break clears it
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			keys <= '0;
		end else if (scan.valid) begin
			for (int i = 0; i < NUM_KEYS; i++) begin
				if (hit[i])
					keys[i] <= !scan.released;
			end
		end
	end

	// Bus payload is unreset, make sure none of it leaks into keys
	assert property (@(posedge clk_sys) disable iff (rst) !$isunknown(keys));

endmodule

// ==== design/ps2_receiver.sv ====
`timescale 1ns/1ns

module ps2_receiver import kbd_pkg::*; #(
	parameter int IDLE_TIMEOUT = 2000
) (
	input  logic         clk_sys,
	input  logic         rst,
	input  logic         ps2_clk,
	input  logic         ps2_data,
	output logic         frame_err,
	scan_bus_if.receiver scan
);

	localparam int IDLE_W = $clog2(IDLE_TIMEOUT + 1);

	logic [1:0]        clk_sync;
	logic [1:0]        data_sync;
	logic              clk_prev;
	logic              clk_fall;
	logic [3:0]        bit_cnt;
	logic [9:0]        shift;
	logic [IDLE_W-1:0] idle_cnt;
	logic              ext_flag;
	logic              brk_flag;
	scan_code_t        rx_byte;
	logic              frame_ok;

	// Both lines idle high
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev  <= clk_sync[1];
		end
	end

	assign clk_fall = clk_prev && !clk_sync[1];

	// shift[0] is start, shift[8:1] data, shift[9] parity; stop is taken live
	assign rx_byte  = shift[8:1];
	assign frame_ok = !shift[0] && (^shift[9:1]) && data_sync[1];

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			bit_cnt    <= '0;
			idle_cnt   <= '0;
			ext_flag   <= 1'b0;
			brk_flag   <= 1'b0;
			frame_err  <= 1'b0;
			scan.valid <= 1'b0;
		end else begin
			frame_err  <= 1'b0;
			scan.valid <= 1'b0;
			if (clk_fall) begin
				idle_cnt <= '0;
				if (bit_cnt == 4'd10) begin
					bit_cnt <= '0;
					if (!frame_ok) begin
						frame_err <= 1'b1;
						ext_flag  <= 1'b0;
						brk_flag  <= 1'b0;
					end else if (rx_byte == PREFIX_EXTENDED) begin
						ext_flag <= 1'b1;
					end else if (rx_byte == PREFIX_BREAK) begin
						brk_flag <= 1'b1;
					end else begin
						scan.valid <= 1'b1;
						ext_flag   <= 1'b0;
						brk_flag   <= 1'b0;
					end
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else if (bit_cnt != '0) begin
				// Drop a frame that stalls halfway
				if (idle_cnt == IDLE_W'(IDLE_TIMEOUT - 1)) begin
					bit_cnt  <= '0;
					idle_cnt <= '0;
				end else begin
					idle_cnt <= idle_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (clk_fall && bit_cnt != 4'd10)
			shift <= {data_sync[1], shift[9:1]};
		if (clk_fall && bit_cnt == 4'd10) begin
			scan.code     <= rx_byte;
			scan.extended <= ext_flag;
			scan.released <= brk_flag;
		end
	end

	// A byte needs a whole frame, so strobes can never touch
	assert property (@(posedge clk_sys) disable iff (rst) scan.valid |=> !scan.valid);

	assert property (@(posedge clk_sys) disable iff (rst) !(frame_err && scan.valid));

endmodule

// ==== design/scan_bus_if.sv ====
`timescale 1ns/1ns

interface scan_bus_if import kbd_pkg::*; ();

	// One cycle strobe per completed data byte
	logic       valid;
	scan_code_t code;
	// Prefix state that went with the byte
	logic       extended;
	logic       released;

	modport receiver (
		output valid,
		output code,
		output extended,
		output released
	);

	modport decoder (
		input valid,
		input code,
		input extended,
		input released
	);

endinterface

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the arcade shell testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module arcade_shell_tb --Mdir obj_dir -o arcade_shell_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/arcade_shell_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
	exit 0
fi
exit 1

// ==== verification/arcade_shell_tb.sv ====
`timescale 1ns/1ns

module arcade_shell_tb import kbd_pkg::*; ();

	localparam int IDLE_TIMEOUT    = 2000;
	localparam int SAMPLE_WIDTH    = 7;
	localparam int CYCLES_PER_LINE = 600;

	logic                    clk_sys;
	logic                    rst;
	logic                    ps2_clk;
	logic                    ps2_data;
	logic [SAMPLE_WIDTH-1:0] audio1;
	logic [SAMPLE_WIDTH-1:0] audio2;
	logic [NUM_KEYS-1:0]     keys;
	logic                    frame_err;
	logic                    audio_out;

	logic [31:0]         lfsr;
	logic [NUM_KEYS-1:0] keys_seen;
	logic [NUM_KEYS-1:0] exp_keys;
	logic                loaded;
	int                  err_pulses = 0;
	int                  exp_err_pulses;
	int                  errors;
	int                  checks;

	// One queue entry per golden data line
	string       tag_q[$];
	logic [31:0] arg1_q[$];
	logic [31:0] arg2_q[$];
	logic [31:0] arg3_q[$];

	arcade_shell #(
		.IDLE_TIMEOUT(IDLE_TIMEOUT),
		.SAMPLE_WIDTH(SAMPLE_WIDTH)
	) arcade_shell_i (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.ps2_clk   (ps2_clk),
		.ps2_data  (ps2_data),
		.audio1    (audio1),
		.audio2    (audio2),
		.keys      (keys),
		.frame_err (frame_err),
		.audio_out (audio_out)
	);

	always #20 clk_sys = ~clk_sys;

	// Frame error strobes over the whole run
	always @(negedge clk_sys) begin
		if (frame_err === 1'b1)
			err_pulses <= err_pulses + 1;
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return r;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
		end
	endtask

	task automatic apply_reset();
		rst <= 1'b1;
		wait_cycles(2);
		rst <= 1'b0;
		wait_cycles(1);
	endtask

	// Start, data LSB first, odd parity and stop bit
	// Keys are sampled 8 cycles after the stop edge
	task automatic send_frame(input logic [7:0] data, input bit bad_parity, input int nbits);
		logic [10:0] bits;
		int          half;
		bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
		for (int i = 0; i < nbits; i++) begin
			half = 10 + rand_bits(2);
			wait_cycles(1);
			ps2_data <= bits[i];
			wait_cycles(half);
			ps2_clk <= 1'b0;
			if (i == 10) begin
				wait_cycles(8);
				@(negedge clk_sys);
				keys_seen = keys;
				wait_cycles(half - 8);
			end else begin
				wait_cycles(half);
			end
			ps2_clk <= 1'b1;
		end
		ps2_data <= 1'b1;
		wait_cycles(20 + rand_bits(3));
	endtask

	// Ones over a full accumulator wrap once the sum has settled
	task automatic measure_audio(input logic [31:0] s1, input logic [31:0] s2,
			input logic [31:0] exp_ones);
		int ones = 0;
		wait_cycles(1);
		audio1 <= s1[SAMPLE_WIDTH-1:0];
		audio2 <= s2[SAMPLE_WIDTH-1:0];
		wait_cycles(4);
		repeat (256) begin
			@(negedge clk_sys);
			ones += audio_out;
		end
		compare("audio_out ones", exp_ones, ones);
	endtask

	task automatic load_golden(output bit ok);
		int          fd;
		int          n;
		string       line;
		string       tag;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		ok = 1'b0;
		fd = $fopen("verification/shell_golden.txt", "r");
		if (fd == 0) begin
			$display("Cannot open verification/shell_golden.txt");
			return;
		end
		while ($fgets(line, fd) != 0) begin
			n = $sscanf(line, "%s %h %h %h", tag, a, b, c);
			if (n == 4 && line.getc(0) != "#") begin
				tag_q.push_back(tag);
				arg1_q.push_back(a);
				arg2_q.push_back(b);
				arg3_q.push_back(c);
			end
		end
		$fclose(fd);
		ok = tag_q.size() > 0;
	endtask

	task automatic run_line(input string tag, input logic [31:0] a, input logic [31:0] b,
			input logic [31:0] c);
		if (tag == "K") begin
			send_frame(a[7:0], 1'b0, 11);
			exp_keys = b[NUM_KEYS-1:0];
			compare("keys", exp_keys, keys_seen);
		end else if (tag == "P") begin
			send_frame(a[7:0], 1'b1, 11);
			exp_err_pulses = b;
			compare("keys", exp_keys, keys_seen);
			compare("frame_err pulses", exp_err_pulses, err_pulses);
		end else if (tag == "C") begin
			// Partial frame then a quiet gap past the idle limit
			send_frame(a[7:0], 1'b0, b);
			wait_cycles(IDLE_TIMEOUT + 100);
			@(negedge clk_sys);
			// A dropped frame raises no frame error
			compare("frame_err pulses", exp_err_pulses, err_pulses);
		end else if (tag == "A") begin
			measure_audio(a, b, c);
		end else if (tag == "R") begin
			wait_cycles(1);
			apply_reset();
			@(negedge clk_sys);
			exp_keys = a[NUM_KEYS-1:0];
			compare("keys", exp_keys, keys);
		end else begin
			errors++;
			$display("Unknown tag %s in the golden file", tag);
		end
	endtask

	initial begin
		bit ok;
		clk_sys        = 1'b0;
		rst            = 1'b1;
		ps2_clk        = 1'b1;
		ps2_data       = 1'b1;
		audio1         = '0;
		audio2         = '0;
		lfsr           = 32'hcf7e_246b;
		exp_keys       = '0;
		exp_err_pulses = 0;
		loaded         = 1'b0;
		errors         = 0;
		checks         = 0;
		load_golden(ok);
		if (!ok) begin
			errors++;
			$display("No stimulus lines could be read from the golden file");
		end else begin
			loaded = 1'b1;
			apply_reset();
			foreach (tag_q[i])
				run_line(tag_q[i], arg1_q[i], arg2_q[i], arg3_q[i]);
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// Budget scales with the number of golden lines
	initial begin
		wait (loaded);
		repeat (tag_q.size() * CYCLES_PER_LINE) @(posedge clk_sys);
		$display("Watchdog expired, the run hung before all golden lines were played");
		$display("Regression failed");
		$finish;
	end

endmodule

// ==== verification/shell_golden.txt ====
# Columns in hex: tag arg1 arg2 arg3
# K byte keys 0 | P byte frame_err_count 0 | C byte bits_sent 0 | A audio1 audio2 ones | R keys 0 0
K E0 000 0
K 74 001 0
K E0 001 0
K 6B 003 0
K E0 003 0
K 75 007 0
K E0 007 0
K 72 00F 0
K 29 01F 0
K 16 03F 0
K 1E 07F 0
K 2E 0FF 0
K 2C 1FF 0
K 31 3FF 0
K F0 3FF 0
K 29 3EF 0
K E0 3EF 0
K F0 3EF 0
K 6B 3ED 0
K 74 3ED 0
K 5A 3ED 0
P 2E 1 0
C 16 5 0
K 29 3FD 0
P F0 2 0
R 000 0 0
K 2E 080 0
A 00 00 000
A 7F 7F 0FE
A 25 13 038
A 01 00 001
